/* rsp_pkg.sv */
`default_nettype none

package rsp_pkg;

  ////////////////////
  // burst geometry
  ////////////////////

  // one sample lane, the wide mode pairs two of these
  localparam int SAMPLE_W = 16;
  localparam int BURST_LEN = 8;
  // 32-bit words per burst
  localparam int WORD_NUM = BURST_LEN / 2;

  // expected bursts per frame
  localparam int FRAME_BURSTS = 16;
  // burst counter, one spare bit so an overlong frame saturates above the target
  localparam int BCNT_W = $clog2(FRAME_BURSTS) + 1;

  // input to output latency of the filter
  localparam int PIPE_LAT = 3;

  ////////////////////
  // clamp limits
  ////////////////////

  // symmetric range, most negative code never produced
  localparam logic signed [SAMPLE_W-1:0] SAT16_POS = 16'sh7FFF;
  localparam logic signed [SAMPLE_W-1:0] SAT16_NEG = 16'sh8001;
  localparam logic signed [2*SAMPLE_W-1:0] SAT32_POS = 32'sh7FFF_FFFF;
  localparam logic signed [2*SAMPLE_W-1:0] SAT32_NEG = 32'sh8000_0001;

  // one 128-bit burst, two's complement lanes
  // lane 0 sits in the low bits
  // word m = {lane 2m+1, lane 2m}
  typedef union packed {
    logic [BURST_LEN-1:0][SAMPLE_W-1:0] lanes;
    logic [WORD_NUM-1:0][2*SAMPLE_W-1:0] words;
  } burst_t;

endpackage

`default_nettype wire

/* rsp_delay.sv */
`default_nettype none

// strobe delay line, keeps control bits in step with the data pipe
module rsp_delay #(
  parameter int DEPTH = 1
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic i_din,
  output logic      o_dout
);

  // shift chain, bit 0 is the newest
  logic [DEPTH-1:0] sr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sr <= '0;
    end else begin
      sr[0] <= i_din;
      for (int k = 1; k < DEPTH; k++) begin
        sr[k] <= sr[k-1];
      end
    end
  end

  // oldest stage
  assign o_dout = sr[DEPTH-1];

endmodule

`default_nettype wire

/* rsp_frame_tracker.sv */
`default_nettype none

module rsp_frame_tracker (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic i_valid,
  input  wire logic i_last,
  output logic      o_first,
  output logic      o_len_err
);

  import rsp_pkg::*;

  // high between the first burst of a frame and its last
  logic frame_open;
  // bursts seen so far in the open frame
  logic [BCNT_W-1:0] bcnt;
  // count including the burst on the input now
  logic [BCNT_W-1:0] bcnt_nxt;

  // closed frame means the next valid opens one
  assign o_first = ~frame_open;

  always_comb begin
    if (!frame_open) begin
      bcnt_nxt = BCNT_W'(1);
    end else if (bcnt == '1) begin
      // hold at full scale, still unequal to the target
      bcnt_nxt = bcnt;
    end else begin
      bcnt_nxt = bcnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_open <= 1'b0;
      bcnt <= '0;
      o_len_err <= 1'b0;
    end else begin
      // single cycle pulse
      o_len_err <= 1'b0;
      if (i_valid) begin
        bcnt <= bcnt_nxt;
        frame_open <= ~i_last;
        if (i_last) begin
          o_len_err <= (bcnt_nxt != BCNT_W'(FRAME_BURSTS));
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rsp_s1_prep_diff.sv */
`default_nettype none

// three-stage first-difference filter over a burst of lanes
//   stage 1 capture, stage 2 subtract, stage 3 clamp
module rsp_s1_prep_diff (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            i_valid,
  input  wire logic            i_first,
  input  wire logic            i_lag1,
  input  wire logic            i_wide,
  input  wire rsp_pkg::burst_t i_data,
  output rsp_pkg::burst_t      o_data
);

  import rsp_pkg::*;

  // stage 1 regs
  burst_t data_r;
  logic valid_r;
  logic first_r;
  logic lag1_r;
  logic wide_r;

  // last two lanes of the previous burst
  logic [SAMPLE_W-1:0] hist6;
  logic [SAMPLE_W-1:0] hist7;

  // sample stream seen by stage 1
  //   [0],[1] previous burst lanes 6,7
  //   [k+2] current lane k
  logic [SAMPLE_W-1:0] seq [BURST_LEN+2];
  // word before each word of the current burst
  logic [2*SAMPLE_W-1:0] prev_word [WORD_NUM];

  // stage 2 regs, one guard bit each
  logic signed [SAMPLE_W:0] d16 [BURST_LEN];
  logic signed [2*SAMPLE_W:0] d32 [WORD_NUM];
  logic valid_2;
  logic wide_2;

  // sign-extended subtract, 16-bit lanes
  function automatic logic [SAMPLE_W:0] sub16(input logic [SAMPLE_W-1:0] a,
                                              input logic [SAMPLE_W-1:0] b);
    return {a[SAMPLE_W-1], a} - {b[SAMPLE_W-1], b};
  endfunction

  // sign-extended subtract, 32-bit words
  function automatic logic [2*SAMPLE_W:0] sub32(input logic [2*SAMPLE_W-1:0] a,
                                                input logic [2*SAMPLE_W-1:0] b);
    return {a[2*SAMPLE_W-1], a} - {b[2*SAMPLE_W-1], b};
  endfunction

  // clamp 17 bits into the symmetric 16-bit range
  function automatic logic [SAMPLE_W-1:0] sat16(input logic signed [SAMPLE_W:0] d);
    if (d > SAT16_POS) begin
      return SAT16_POS;
    end else if (d < SAT16_NEG) begin
      return SAT16_NEG;
    end
    return d[SAMPLE_W-1:0];
  endfunction

  // clamp 33 bits into the symmetric 32-bit range
  function automatic logic [2*SAMPLE_W-1:0] sat32(input logic signed [2*SAMPLE_W:0] d);
    if (d > SAT32_POS) begin
      return SAT32_POS;
    end else if (d < SAT32_NEG) begin
      return SAT32_NEG;
    end
    return d[2*SAMPLE_W-1:0];
  endfunction

  ////////////////////
  // stage 1
  ////////////////////

  // burst payload, loaded only on a valid
  always_ff @(posedge clk) begin
    if (i_valid) begin
      data_r <= i_data;
    end
  end

  // modes ride along with the burst
  // so a mode change between frames never hits a burst in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_r <= 1'b0;
      first_r <= 1'b0;
      lag1_r <= 1'b0;
      wide_r <= 1'b0;
    end else begin
      valid_r <= i_valid;
      if (i_valid) begin
        first_r <= i_first;
        lag1_r <= i_lag1;
        wide_r <= i_wide;
      end
    end
  end

  // history follows the burst leaving stage 1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hist6 <= '0;
      hist7 <= '0;
    end else if (valid_r) begin
      hist6 <= data_r.lanes[BURST_LEN-2];
      hist7 <= data_r.lanes[BURST_LEN-1];
    end
  end

  // first burst of a frame sees zero history
  // masked at use, the stored history may still belong to a burst ahead of it
  always_comb begin
    seq[0] = first_r ? '0 : hist6;
    seq[1] = first_r ? '0 : hist7;
    for (int k = 0; k < BURST_LEN; k++) begin
      seq[k+2] = data_r.lanes[k];
    end
    prev_word[0] = {seq[1], seq[0]};
    for (int m = 1; m < WORD_NUM; m++) begin
      prev_word[m] = data_r.words[m-1];
    end
  end

  ////////////////////
  // stage 2
  ////////////////////

  always_ff @(posedge clk) begin
    if (valid_r) begin
      for (int k = 0; k < BURST_LEN; k++) begin
        // lag 1 vs lag 2 within the 16-bit stream
        if (lag1_r) begin
          d16[k] <= sub16(seq[k+2], seq[k+1]);
        end else begin
          d16[k] <= sub16(seq[k+2], seq[k]);
        end
      end
      for (int m = 0; m < WORD_NUM; m++) begin
        d32[m] <= sub32(data_r.words[m], prev_word[m]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_2 <= 1'b0;
      wide_2 <= 1'b0;
    end else begin
      valid_2 <= valid_r;
      if (valid_r) begin
        wide_2 <= wide_r;
      end
    end
  end

  ////////////////////
  // stage 3
  ////////////////////

  // wide mode writes through the word view
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_data <= '0;
    end else if (valid_2) begin
      if (wide_2) begin
        for (int m = 0; m < WORD_NUM; m++) begin
          o_data.words[m] <= sat32(d32[m]);
        end
      end else begin
        for (int k = 0; k < BURST_LEN; k++) begin
          o_data.lanes[k] <= sat16(d16[k]);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rsp_s1_prep.sv */
`default_nettype none

module rsp_s1_prep (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            i_valid,
  input  wire logic            i_last,
  input  wire logic            i_lag1,
  input  wire logic            i_wide,
  input  wire rsp_pkg::burst_t i_data,
  output logic                 o_valid,
  output logic                 o_last,
  output rsp_pkg::burst_t      o_data,
  output logic                 o_frame_err
);

  import rsp_pkg::*;

  // input cycle opens a frame
  logic first;
  // length check, one cycle after the input last
  logic len_err;

  rsp_frame_tracker u_tracker (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_valid   (i_valid),
    .i_last    (i_last),
    .o_first   (first),
    .o_len_err (len_err)
  );

  rsp_s1_prep_diff u_diff (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_valid),
    .i_first (first),
    .i_lag1  (i_lag1),
    .i_wide  (i_wide),
    .i_data  (i_data),
    .o_data  (o_data)
  );

  // strobes matched to the filter latency
  rsp_delay #(.DEPTH(PIPE_LAT)) u_dly_valid (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_din  (i_valid),
    .o_dout (o_valid)
  );

  rsp_delay #(.DEPTH(PIPE_LAT)) u_dly_last (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_din  (i_last),
    .o_dout (o_last)
  );

  // tracker already spent one cycle
  rsp_delay #(.DEPTH(PIPE_LAT - 1)) u_dly_err (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_din  (len_err),
    .o_dout (o_frame_err)
  );

endmodule

`default_nettype wire

/* rsp_s1_prep_properties.sv */
`default_nettype none

// output checks bound into the rsp_s1_prep top level
module rsp_s1_prep_properties (
  input wire logic            clk,
  input wire logic            rst_n,
  input wire logic            i_valid,
  input wire logic            i_last,
  input wire logic            i_lag1,
  input wire logic            i_wide,
  input wire rsp_pkg::burst_t i_data,
  input wire logic            o_valid,
  input wire logic            o_last,
  input wire rsp_pkg::burst_t o_data,
  input wire logic            o_frame_err
);
  timeunit 1ns;
  timeprecision 1ps;

  import rsp_pkg::*;

  // count of failed assertions
  int err_cnt = 0;

  // reference model state
  logic [SAMPLE_W-1:0] prev [BURST_LEN];
  logic open_f;
  int bursts;
  int cnt_new;
  // expected values where index PIPE_LAT-1 lines up with the outputs
  burst_t exp_q [PIPE_LAT];
  logic [PIPE_LAT-1:0] v_q;
  logic [PIPE_LAT-1:0] l_q;
  logic [PIPE_LAT-1:0] e_q;

  function automatic longint clamp(input longint v, input longint lim);
    if (v > lim) begin
      return lim;
    end else if (v < -lim) begin
      return -lim;
    end
    return v;
  endfunction

  // integer model of the stream made of the previous burst then the current one
  function automatic burst_t expect_burst(input burst_t cur, input logic lag1,
                                          input logic wide, input logic first);
    longint s [2*BURST_LEN];
    longint w [BURST_LEN];
    burst_t r;
    for (int k = 0; k < BURST_LEN; k++) begin
      s[k] = first ? 64'sd0 : longint'($signed(prev[k]));
      s[k+BURST_LEN] = longint'($signed(cur.lanes[k]));
    end
    // 32-bit samples with the odd lane as the high half
    for (int j = 0; j < BURST_LEN; j++) begin
      w[j] = s[2*j+1] * 65536 + (s[2*j] & 65535);
    end
    for (int k = 0; k < BURST_LEN; k++) begin
      r.lanes[k] = 16'(clamp(s[k+BURST_LEN] - s[k+BURST_LEN-(lag1 ? 1 : 2)], 32767));
    end
    if (wide) begin
      for (int m = 0; m < WORD_NUM; m++) begin
        r.words[m] = 32'(clamp(w[m+WORD_NUM] - w[m+WORD_NUM-1], 64'sh7FFF_FFFF));
      end
    end
    return r;
  endfunction

  assign cnt_new = open_f ? bursts + 1 : 1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      open_f <= 1'b0;
      bursts <= 0;
      v_q <= '0;
      l_q <= '0;
      e_q <= '0;
      for (int k = 0; k < BURST_LEN; k++) begin
        prev[k] <= '0;
      end
      for (int p = 0; p < PIPE_LAT; p++) begin
        exp_q[p] <= '0;
      end
    end else begin
      v_q <= {v_q[PIPE_LAT-2:0], i_valid};
      l_q <= {l_q[PIPE_LAT-2:0], i_last};
      e_q <= {e_q[PIPE_LAT-2:0], i_valid & i_last & (cnt_new != FRAME_BURSTS)};
      exp_q[0] <= expect_burst(i_data, i_lag1 & ~i_wide, i_wide, ~open_f);
      for (int p = 1; p < PIPE_LAT; p++) begin
        exp_q[p] <= exp_q[p-1];
      end
      if (i_valid) begin
        bursts <= cnt_new;
        open_f <= ~i_last;
        for (int k = 0; k < BURST_LEN; k++) begin
          prev[k] <= i_data.lanes[k];
        end
      end
    end
  end

  ////////////////////
  // assertions
  ////////////////////

  // everything idle right out of reset
  a_reset: assert property (@(posedge clk) $rose(rst_n) |->
      (o_data == '0 && !o_valid && !o_last && !o_frame_err))
    else begin
      err_cnt++;
      $error("** Error outputs after reset o_data %h o_valid %h o_last %h o_frame_err %h",
             $sampled(o_data), $sampled(o_valid), $sampled(o_last), $sampled(o_frame_err));
    end

  a_valid: assert property (@(posedge clk) disable iff (!rst_n) o_valid == v_q[PIPE_LAT-1])
    else begin
      err_cnt++;
      $error("** Error o_valid got %h expected %h", $sampled(o_valid), $sampled(v_q[PIPE_LAT-1]));
    end

  a_last: assert property (@(posedge clk) disable iff (!rst_n) o_last == l_q[PIPE_LAT-1])
    else begin
      err_cnt++;
      $error("** Error o_last got %h expected %h", $sampled(o_last), $sampled(l_q[PIPE_LAT-1]));
    end

  a_ferr: assert property (@(posedge clk) disable iff (!rst_n) o_frame_err == e_q[PIPE_LAT-1])
    else begin
      err_cnt++;
      $error("** Error o_frame_err got %h expected %h", $sampled(o_frame_err),
             $sampled(e_q[PIPE_LAT-1]));
    end

  a_data: assert property (@(posedge clk) disable iff (!rst_n)
      o_valid |-> o_data == exp_q[PIPE_LAT-1])
    else begin
      err_cnt++;
      $error("** Error o_data got %h expected %h", $sampled(o_data),
             $sampled(exp_q[PIPE_LAT-1]));
    end

endmodule

`default_nettype wire

/* tb_rsp_s1_prep.sv */
`default_nettype none

module tb_rsp_s1_prep;
  timeunit 1ns;
  timeprecision 1ps;

  import rsp_pkg::*;

  localparam int N_FRAMES = 8;
  // gap after a burst is 0 .. MAX_GAP-1 idle cycles
  localparam int MAX_GAP = 4;
  localparam int WATCHDOG_NS = N_FRAMES * FRAME_BURSTS * (MAX_GAP + 1) * 8 + 1000;

  logic clk;
  logic rst_n;
  logic i_valid;
  logic i_last;
  logic i_lag1;
  logic i_wide;
  burst_t i_data;
  logic o_valid;
  logic o_last;
  burst_t o_data;
  logic o_frame_err;
  integer seed;

  rsp_s1_prep dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_valid     (i_valid),
    .i_last      (i_last),
    .i_lag1      (i_lag1),
    .i_wide      (i_wide),
    .i_data      (i_data),
    .o_valid     (o_valid),
    .o_last      (o_last),
    .o_data      (o_data),
    .o_frame_err (o_frame_err)
  );

  bind rsp_s1_prep rsp_s1_prep_properties u_props (
    .clk(clk), .rst_n(rst_n), .i_valid(i_valid), .i_last(i_last), .i_lag1(i_lag1),
    .i_wide(i_wide), .i_data(i_data), .o_valid(o_valid), .o_last(o_last),
    .o_data(o_data), .o_frame_err(o_frame_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // random lanes with extremes mixed in
  // extreme bursts alternate the two 32-bit limits word by word
  function automatic burst_t make_burst(input logic extreme);
    logic [3:0][SAMPLE_W-1:0] pat = {16'h8000, 16'h0000, 16'h7FFF, 16'hFFFF};
    logic [3:0][SAMPLE_W-1:0] ext = {16'hFFFF, 16'h8001, 16'h8000, 16'h7FFF};
    logic [2:0] sel;
    burst_t b;
    for (int k = 0; k < BURST_LEN; k++) begin
      sel = 3'($random(seed));
      if (extreme) begin
        b.lanes[k] = pat[k%4];
      end else if (!sel[2]) begin
        b.lanes[k] = ext[sel[1:0]];
      end else begin
        b.lanes[k] = 16'($random(seed));
      end
    end
    return b;
  endfunction

  // sends one frame starting and ending on a falling edge
  task automatic send_frame(input int nbursts, input logic lag1, input logic wide,
                            input int max_gap);
    int gap;
    i_lag1 = lag1;
    i_wide = wide;
    for (int b = 0; b < nbursts; b++) begin
      i_valid = 1'b1;
      i_last = (b == nbursts - 1);
      i_data = make_burst(b % 4 == 3);
      @(negedge clk);
      i_valid = 1'b0;
      i_last = 1'b0;
      gap = (max_gap > 0) ? int'($unsigned($random(seed)) % max_gap) : 0;
      repeat (gap) @(negedge clk);
    end
  endtask

  // first failing assertion ends the run
  always @(dut0.u_props.err_cnt) begin
    if (dut0.u_props.err_cnt != 0) begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "an output check failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired before the stimulus finished");
  end

  initial begin
    seed = 32'hb93a;
    rst_n = 1'b0;
    i_valid = 1'b0;
    i_last = 1'b0;
    i_lag1 = 1'b0;
    i_wide = 1'b0;
    i_data = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // each mode with random gaps
    send_frame(FRAME_BURSTS, 1'b0, 1'b0, MAX_GAP);
    send_frame(FRAME_BURSTS, 1'b1, 1'b0, MAX_GAP);
    send_frame(FRAME_BURSTS, 1'b0, 1'b1, MAX_GAP);
    // back to back frames where the second has both mode bits set
    send_frame(FRAME_BURSTS, 1'b0, 1'b0, 0);
    send_frame(FRAME_BURSTS, 1'b1, 1'b1, 0);
    // short frame flags a length error
    send_frame(5, 1'b1, 1'b0, MAX_GAP);
    // overlong frame runs the burst counter past its full scale
    send_frame((1 << BCNT_W) + FRAME_BURSTS, 1'b0, 1'b0, 0);
    send_frame(FRAME_BURSTS, 1'b0, 1'b0, MAX_GAP);
    repeat (2 * PIPE_LAT) @(negedge clk);
    if (dut0.u_props.err_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "output checks failed");
    end
  end

endmodule

`default_nettype wire

/* all.f */
rsp_pkg.sv
rsp_delay.sv
rsp_frame_tracker.sv
rsp_s1_prep_diff.sv
rsp_s1_prep.sv
rsp_s1_prep_properties.sv
tb_rsp_s1_prep.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rsp_s1_prep -f all.f \
  && ./obj_dir/Vtb_rsp_s1_prep +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: FAIL" sim.log && echo "simulation failed" && exit 1
grep -q "TEST RESULT: PASS" sim.log || { echo "no verdict in sim.log"; exit 1; }
exit 0
